// ==== source/async_fifo_pkg.sv ====
package async_fifo_pkg;

	// defaults picked up by the top level and the testbench
	localparam int DEFAULT_WIDTH = 8;
	localparam int DEFAULT_DEPTH = 16;

	// widest pointer the conversion functions handle
	localparam int MAX_PTR_WIDTH = 32;

	typedef logic [MAX_PTR_WIDTH-1:0] ptr_t;

	// callers zero-extend narrower pointers into ptr_t
	function automatic ptr_t bin_to_gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	// running xor from the msb down
	function automatic ptr_t gray_to_bin(input ptr_t gray);
		ptr_t bin;
		bin[MAX_PTR_WIDTH-1] = gray[MAX_PTR_WIDTH-1];
		for (int i = MAX_PTR_WIDTH - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

// ==== source/dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram #(
	parameter int WIDTH      = 8,
	parameter int ADDR_WIDTH = 4
) (
	input  logic                  wclk,
	input  logic                  wenc,
	input  logic [ADDR_WIDTH-1:0] waddr,
	input  logic [WIDTH-1:0]      wdata,
	input  logic                  rclk,
	input  logic                  rrstn,
	input  logic                  renc,
	input  logic [ADDR_WIDTH-1:0] raddr,
	output logic [WIDTH-1:0]      rdata
);

	logic [WIDTH-1:0] mem [2**ADDR_WIDTH];

	always_ff @(posedge wclk) begin
		if (wenc) begin
			mem[waddr] <= wdata;
		end
	end

	// rdata holds between pops
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rdata <= '0;
		end else if (renc) begin
			rdata <= mem[raddr];
		end
	end

endmodule

// ==== source/gray_ptr_sync.sv ====
`timescale 1ns/1ps

module gray_ptr_sync #(
	parameter int PTR_WIDTH = 5
) (
	input  logic                 dst_clk,
	input  logic                 dst_rstn,
	input  logic [PTR_WIDTH-1:0] gray_in,
	output logic [PTR_WIDTH-1:0] gray_out
);

	logic [PTR_WIDTH-1:0] gray_buff;

	// only one bit of gray_in moves per source edge, so a
	// metastable first stage settles to old or new value
	always_ff @(posedge dst_clk or negedge dst_rstn) begin
		if (!dst_rstn) begin
			gray_buff <= '0;
			gray_out  <= '0;
		end else begin
			gray_buff <= gray_in;
			gray_out  <= gray_buff;
		end
	end

endmodule

// ==== source/wr_ptr_full.sv ====
`timescale 1ns/1ps

module wr_ptr_full #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                  wclk,
	input  logic                  wrstn,
	input  logic                  winc,
	input  logic [ADDR_WIDTH:0]   rptr_syn,
	output logic                  wfull,
	output logic                  wen,
	output logic [ADDR_WIDTH-1:0] waddr,
	output logic [ADDR_WIDTH:0]   wptr,
	output logic [ADDR_WIDTH:0]   wr_level
);

	import async_fifo_pkg::*;

	localparam int PTR_WIDTH = ADDR_WIDTH + 1;

	logic [ADDR_WIDTH:0] waddr_bin;
	logic [ADDR_WIDTH:0] waddr_gray;
	logic [ADDR_WIDTH:0] rptr_bin;

	assign wen = winc & ~wfull;

	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			waddr_bin <= '0;
		end else if (wen) begin
			waddr_bin <= waddr_bin + 1'b1;
		end
	end

	assign waddr_gray = PTR_WIDTH'(bin_to_gray(ptr_t'(waddr_bin)));

	// gray copy for the read side, one wclk behind waddr_bin
	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			wptr <= '0;
		end else begin
			wptr <= waddr_gray;
		end
	end

	// full when write is one lap ahead of the synced read pointer.
	// uses the gray of the current binary pointer so a write on
	// the previous edge already counts
	assign wfull = (waddr_gray ==
		{~rptr_syn[ADDR_WIDTH:ADDR_WIDTH-1], rptr_syn[ADDR_WIDTH-2:0]});

	assign waddr = waddr_bin[ADDR_WIDTH-1:0];

	// stale rptr_syn only overstates the level
	assign rptr_bin = PTR_WIDTH'(gray_to_bin(ptr_t'(rptr_syn)));
	assign wr_level = waddr_bin - rptr_bin;

endmodule

// ==== source/rd_ptr_empty.sv ====
`timescale 1ns/1ps

module rd_ptr_empty #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                  rclk,
	input  logic                  rrstn,
	input  logic                  rinc,
	input  logic [ADDR_WIDTH:0]   wptr_syn,
	output logic                  rempty,
	output logic                  ren,
	output logic [ADDR_WIDTH-1:0] raddr,
	output logic [ADDR_WIDTH:0]   rptr,
	output logic [ADDR_WIDTH:0]   rd_level
);

	import async_fifo_pkg::*;

	localparam int PTR_WIDTH = ADDR_WIDTH + 1;

	logic [ADDR_WIDTH:0] raddr_bin;
	logic [ADDR_WIDTH:0] raddr_gray;
	logic [ADDR_WIDTH:0] wptr_bin;

	assign ren = rinc & ~rempty;

	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			raddr_bin <= '0;
		end else if (ren) begin
			raddr_bin <= raddr_bin + 1'b1;
		end
	end

	assign raddr_gray = PTR_WIDTH'(bin_to_gray(ptr_t'(raddr_bin)));

	// gray copy for the write side, one rclk behind raddr_bin
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rptr <= '0;
		end else begin
			rptr <= raddr_gray;
		end
	end

	// empty when the read pointer has caught the synced write pointer,
	// counting a pop on the previous edge at once
	assign rempty = (raddr_gray == wptr_syn);

	assign raddr = raddr_bin[ADDR_WIDTH-1:0];

	// stale wptr_syn only understates the level
	assign wptr_bin = PTR_WIDTH'(gray_to_bin(ptr_t'(wptr_syn)));
	assign rd_level = wptr_bin - raddr_bin;

endmodule

// ==== source/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo #(
	parameter int WIDTH       = async_fifo_pkg::DEFAULT_WIDTH,
	parameter int DEPTH       = async_fifo_pkg::DEFAULT_DEPTH,
	localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
	input  logic                wclk,
	input  logic                wrstn,
	input  logic                winc,
	input  logic [WIDTH-1:0]    wdata,
	input  logic                rclk,
	input  logic                rrstn,
	input  logic                rinc,
	output logic                wfull,
	output logic [ADDR_WIDTH:0] wr_level,
	output logic                rempty,
	output logic [WIDTH-1:0]    rdata,
	output logic [ADDR_WIDTH:0] rd_level
);

	logic                  wen;
	logic                  ren;
	logic [ADDR_WIDTH-1:0] waddr;
	logic [ADDR_WIDTH-1:0] raddr;
	logic [ADDR_WIDTH:0]   wptr;
	logic [ADDR_WIDTH:0]   rptr;
	logic [ADDR_WIDTH:0]   wptr_syn;
	logic [ADDR_WIDTH:0]   rptr_syn;

	dual_port_ram #(
		.WIDTH      (WIDTH),
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_ram (
		.wclk  (wclk),
		.wenc  (wen),
		.waddr (waddr),
		.wdata (wdata),
		.rclk  (rclk),
		.rrstn (rrstn),
		.renc  (ren),
		.raddr (raddr),
		.rdata (rdata)
	);

	// write domain
	wr_ptr_full #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_wr_ptr_full (
		.wclk     (wclk),
		.wrstn    (wrstn),
		.winc     (winc),
		.rptr_syn (rptr_syn),
		.wfull    (wfull),
		.wen      (wen),
		.waddr    (waddr),
		.wptr     (wptr),
		.wr_level (wr_level)
	);

	// read domain
	rd_ptr_empty #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_rd_ptr_empty (
		.rclk     (rclk),
		.rrstn    (rrstn),
		.rinc     (rinc),
		.wptr_syn (wptr_syn),
		.rempty   (rempty),
		.ren      (ren),
		.raddr    (raddr),
		.rptr     (rptr),
		.rd_level (rd_level)
	);

	// write pointer into rclk
	gray_ptr_sync #(
		.PTR_WIDTH (ADDR_WIDTH + 1)
	) u_wptr_sync (
		.dst_clk  (rclk),
		.dst_rstn (rrstn),
		.gray_in  (wptr),
		.gray_out (wptr_syn)
	);

	// read pointer into wclk
	gray_ptr_sync #(
		.PTR_WIDTH (ADDR_WIDTH + 1)
	) u_rptr_sync (
		.dst_clk  (wclk),
		.dst_rstn (wrstn),
		.gray_in  (rptr),
		.gray_out (rptr_syn)
	);

endmodule

// ==== include/tb_lfsr.svh ====
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// starting state for all random stimulus
localparam logic [31:0] LFSR_SEED = 32'hf4bd_7597;

// x^32 + x^22 + x^2 + x + 1, maximal length
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic fb;
	fb = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], fb};
endfunction

// one random bit per step, taken from the top of the register
function automatic logic lfsr_bit(input logic [31:0] state);
	return state[31];
endfunction

`endif

// ==== tb/tb_async_fifo.sv ====
`timescale 1ns/1ps

module tb_async_fifo;

	import async_fifo_pkg::*;

	`include "tb_lfsr.svh"

	localparam int WIDTH        = DEFAULT_WIDTH;
	localparam int DEPTH        = DEFAULT_DEPTH;
	localparam int AW           = $clog2(DEPTH);
	localparam int WAIT_LIMIT   = 20000;
	localparam int PHASE_WRITES = 300;

	localparam int MODE_OFF    = 0;
	localparam int MODE_RANDOM = 1;
	localparam int MODE_ON     = 2;

	logic             wclk = 1'b0;
	logic             rclk = 1'b0;
	logic             wrstn;
	logic             rrstn;
	logic             winc;
	logic [WIDTH-1:0] wdata;
	logic             rinc;
	logic             wfull;
	logic [AW:0]      wr_level;
	logic             rempty;
	logic [WIDTH-1:0] rdata;
	logic [AW:0]      rd_level;

	realtime          wclk_half  = 7.0;
	int               wr_mode    = MODE_OFF;
	int               rd_mode    = MODE_OFF;
	logic             pop_once   = 1'b0;
	int               wr_count   = 0;
	int               rd_count   = 0;
	logic             popped     = 1'b0;
	logic [WIDTH-1:0] last_rdata = '0;
	logic [31:0]      wr_lfsr    = LFSR_SEED;
	logic [31:0]      rd_lfsr    = LFSR_SEED;
	logic             rd_bit;
	int               errors     = 0;
	int               timeouts   = 0;

	async_fifo #(
		.WIDTH (WIDTH),
		.DEPTH (DEPTH)
	) u_async_fifo (
		.wclk     (wclk),
		.wrstn    (wrstn),
		.winc     (winc),
		.wdata    (wdata),
		.rclk     (rclk),
		.rrstn    (rrstn),
		.rinc     (rinc),
		.wfull    (wfull),
		.wr_level (wr_level),
		.rempty   (rempty),
		.rdata    (rdata),
		.rd_level (rd_level)
	);

	always #5 rclk = ~rclk;

	// half period drops from 7 to 3 for the second phase
	always #(wclk_half) wclk = ~wclk;

	// n-th word ever written
	function automatic logic [WIDTH-1:0] expected_word(input int n);
		logic [31:0] mix;
		mix = (n + 1) * 32'h9e37_79b1;
		mix = mix ^ (mix >> 15);
		return mix[WIDTH-1:0];
	endfunction

	function automatic int clamp_range(input int value, input int lo, input int hi);
		if (value < lo) begin
			return lo;
		end
		if (value > hi) begin
			return hi;
		end
		return value;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("FAIL at %0t: %s got %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic wait_writes(input int target);
		int n;
		n = 0;
		while (wr_count < target && n < WAIT_LIMIT) begin
			@(negedge wclk);
			n++;
		end
		if (wr_count < target) begin
			timeouts++;
			$display("timeout: only %0d of %0d writes accepted at %0t",
				wr_count, target, $time);
		end
	endtask

	task automatic wait_wfull(input logic level);
		int n;
		n = 0;
		while (wfull !== level && n < WAIT_LIMIT) begin
			@(negedge wclk);
			n++;
		end
		if (wfull !== level) begin
			timeouts++;
			$display("timeout: wfull never went to %0b by %0t", level, $time);
		end
	endtask

	// no write may still be pending once the FIFO counts as drained
	task automatic wait_drained();
		int n;
		n = 0;
		while ((rd_count != wr_count || rempty !== 1'b1 || winc !== 1'b0)
			&& n < WAIT_LIMIT) begin
			@(negedge rclk);
			n++;
		end
		if (rd_count != wr_count || rempty !== 1'b1 || winc !== 1'b0) begin
			timeouts++;
			$display("timeout: FIFO did not drain, %0d written and %0d read at %0t",
				wr_count, rd_count, $time);
		end
	endtask

	// both levels must reach the true count once traffic has stopped
	task automatic wait_settled();
		int n;
		n = 0;
		while ((wr_level !== wr_count - rd_count || rd_level !== wr_count - rd_count)
			&& n < WAIT_LIMIT) begin
			@(negedge rclk);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			timeouts++;
			$display("timeout: levels did not settle by %0t", $time);
		end
		check_eq("wr_level", wr_level, wr_count - rd_count);
		check_eq("rd_level", rd_level, wr_count - rd_count);
	endtask

	// write side bookkeeping on pre-edge values
	always @(posedge wclk) begin
		if (wrstn && rrstn) begin
			check_eq("wr_level", wr_level,
				clamp_range(wr_level, wr_count - rd_count, DEPTH));
			if (winc && !wfull) begin
				wr_count++;
			end
		end
	end

	always @(posedge rclk) begin
		if (wrstn && rrstn) begin
			check_eq("rd_level", rd_level,
				clamp_range(rd_level, 0, wr_count - rd_count));
			popped = rinc && !rempty;
			if (popped) begin
				rd_count++;
			end
		end else begin
			popped = 1'b0;
		end
	end

	// rdata is compared mid-cycle and moves only on a pop
	always @(negedge rclk) begin
		if (rrstn) begin
			if (popped) begin
				check_eq("rdata", rdata, expected_word(rd_count - 1));
			end else begin
				check_eq("rdata", rdata, last_rdata);
			end
		end
		last_rdata = rdata;
	end

	initial begin
		forever begin
			@(posedge wclk);
			#1;
			if (wr_mode == MODE_RANDOM) begin
				wr_lfsr = lfsr_next(wr_lfsr);
				winc = lfsr_bit(wr_lfsr);
			end else begin
				winc = (wr_mode == MODE_ON);
			end
			wdata = expected_word(wr_count);
		end
	end

	initial begin
		forever begin
			@(posedge rclk);
			#1;
			if (pop_once) begin
				rinc = 1'b1;
				pop_once = 1'b0;
			end else if (rd_mode == MODE_RANDOM) begin
				rd_lfsr = lfsr_next(rd_lfsr);
				rd_bit = lfsr_bit(rd_lfsr);
				rd_lfsr = lfsr_next(rd_lfsr);
				rinc = rd_bit | lfsr_bit(rd_lfsr);
			end else begin
				rinc = (rd_mode == MODE_ON);
			end
		end
	end

	initial begin
		int c0;
		int w0;
		wrstn = 1'b0;
		rrstn = 1'b0;
		winc  = 1'b0;
		rinc  = 1'b0;
		wdata = '0;
		fork
			begin
				repeat (16) @(posedge rclk);
				#1;
				rrstn = 1'b1;
			end
			begin
				repeat (16) @(posedge wclk);
				#1;
				wrstn = 1'b1;
			end
		join
		@(negedge rclk);
		check_eq("wfull", wfull, 0);
		check_eq("rempty", rempty, 1);
		check_eq("wr_level", wr_level, 0);
		check_eq("rd_level", rd_level, 0);
		check_eq("rdata", rdata, 0);

		// random traffic with the write clock slower than the read clock
		wr_mode = MODE_RANDOM;
		rd_mode = MODE_RANDOM;
		wait_writes(PHASE_WRITES);
		wclk_half = 3.0;
		wait_writes(2 * PHASE_WRITES);
		wr_mode = MODE_OFF;
		rd_mode = MODE_ON;
		wait_drained();
		wait_settled();
		check_eq("words read", rd_count, wr_count);

		// fill with reads stopped
		rd_mode = MODE_OFF;
		repeat (3) @(negedge rclk);
		c0 = wr_count;
		wr_mode = MODE_ON;
		wait_wfull(1'b1);
		check_eq("words accepted", wr_count - c0, DEPTH);
		repeat (20) begin
			@(negedge wclk);
			check_eq("wfull", wfull, 1);
		end
		check_eq("words accepted", wr_count - c0, DEPTH);

		// single pop at full makes room for exactly one write
		@(negedge rclk);
		pop_once = 1'b1;
		wait_wfull(1'b0);
		w0 = wr_count;
		wait_wfull(1'b1);
		check_eq("writes after pop", wr_count - w0, 1);
		check_eq("fill count", wr_count - rd_count, DEPTH);

		// drain and then keep rinc high on an empty FIFO
		wr_mode = MODE_OFF;
		rd_mode = MODE_ON;
		wait_drained();
		c0 = rd_count;
		repeat (20) begin
			@(negedge rclk);
			check_eq("rempty", rempty, 1);
		end
		check_eq("read index", rd_count, c0);
		rd_mode = MODE_OFF;
		wait_settled();
		check_eq("words read", rd_count, wr_count);

		$display("errors: %0d, timeouts: %0d, words written: %0d, words read: %0d",
			errors, timeouts, wr_count, rd_count);
		if (errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== async_fifo.f ====
+incdir+include
source/async_fifo_pkg.sv
source/dual_port_ram.sv
source/gray_ptr_sync.sv
source/wr_ptr_full.sv
source/rd_ptr_empty.sv
source/async_fifo.sv
tb/tb_async_fifo.sv
